// ==== hw/obj_pkg.sv ====
package obj_pkg;

    // board sizes, all fixed
    localparam int OBJ_COUNT = 64;   // objects in the table and slots per line
    localparam int SLOT_W    = 6;    // slot / object index width
    localparam int OBJ_H     = 16;   // object height in lines

    // beam limits
    localparam int H_ACTIVE  = 256;  // pixels scanned per line
    localparam int H_TOTAL   = 320;  // pixel clocks per line incl. blanking
    localparam int V_TOTAL   = 256;  // lines per frame, no vblank modelled

    // one object attribute table word, 29 bits
    typedef struct packed {
        logic       enable;
        logic [7:0] y;        // top line
        logic [7:0] x;
        logic [6:0] tile;
        logic [2:0] palette;
        logic       hflip;
        logic       vflip;
    } obj_attr_t;

    // one sprite slice as kept in the line buffer, 24 bits
    typedef struct packed {
        logic       valid;
        logic [5:0] obj_id;   // table index
        logic [6:0] tile;
        logic [2:0] palette;
        logic       hflip;
        logic [3:0] row;      // vflip already applied
        logic [1:0] sub_x;    // x mod 4
    } line_entry_t;

    // scanner -> line buffer
    typedef struct packed {
        logic        we;
        logic [5:0]  slot;
        line_entry_t entry;
    } lb_wr_t;

    // beam position
    typedef struct packed {
        logic [8:0] h;
        logic [7:0] v;
        logic       hblank;   // h >= H_ACTIVE
    } beam_t;

endpackage

// ==== hw/obj_ram.sv ====
`timescale 1ns/100ps

module obj_ram #(
    parameter type payload_t = logic [7:0]
) (
    input  logic                        clk,
    input  logic                        cen,
    input  logic                        we,
    input  logic [obj_pkg::SLOT_W-1:0]  waddr,
    input  payload_t                    wdata,
    input  logic [obj_pkg::SLOT_W-1:0]  raddr,
    output payload_t                    rdata
);

    payload_t mem [obj_pkg::OBJ_COUNT];  // no reset, contents undefined until written

    // write side runs every clock, strobes need not line up with cen
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read side, one register on cen
    // same-address write in that clock -> old word comes out
    always_ff @(posedge clk) begin
        if (cen) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== hw/hv_counter.sv ====
`timescale 1ns/100ps

module hv_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pxl_cen,
    output obj_pkg::beam_t  beam
);

    logic [8:0] h;
    logic [7:0] v;
    logic       hblank;
    logic [8:0] h_nxt;
    logic [7:0] v_nxt;
    logic       h_wrap;

    // next beam position
    always_comb begin
        h_wrap = (h == 9'(obj_pkg::H_TOTAL - 1));   // last pixel clock of the line
        h_nxt  = h_wrap ? 9'd0 : h + 9'd1;
        if (h_wrap) begin
            v_nxt = (v == 8'(obj_pkg::V_TOTAL - 1)) ? 8'd0 : v + 8'd1;
        end else begin
            v_nxt = v;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h      <= 9'd0;
            v      <= 8'd0;
            hblank <= 1'b0;              // h = 0 is active
        end else if (pxl_cen) begin
            h      <= h_nxt;
            v      <= v_nxt;
            // registered together with h so it always matches
            hblank <= (h_nxt >= 9'(obj_pkg::H_ACTIVE));
        end
    end

    assign beam.h      = h;
    assign beam.v      = v;
    assign beam.hblank = hblank;

endmodule

// ==== hw/obj_scan.sv ====
`timescale 1ns/100ps

module obj_scan (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pxl_cen,
    input  logic                cpu_we,
    input  logic [5:0]          cpu_addr,
    input  obj_pkg::obj_attr_t  cpu_data,
    input  obj_pkg::beam_t      beam,
    output obj_pkg::lb_wr_t     wr
);

    logic [obj_pkg::SLOT_W-1:0] tbl_raddr;
    obj_pkg::obj_attr_t         attr;        // object of the current slot
    logic                       zone_tick;   // h mod 4 = 1 during active time
    logic [7:0]                 target;      // line being prepared
    logic [7:0]                 diff;
    logic                       hit;
    obj_pkg::line_entry_t       ent_nxt;

    logic                       we_q;
    logic [5:0]                 slot_q;
    obj_pkg::line_entry_t       entry_q;

    // object s is addressed over the whole slot, sampled by the RAM at h mod 4 = 0
    assign tbl_raddr = beam.h[7:2];

    // object attribute table, written by the CPU at any time
    obj_ram #(
        .payload_t (obj_pkg::obj_attr_t)
    ) u_table (
        .clk   (clk),
        .cen   (pxl_cen),
        .we    (cpu_we),
        .waddr (cpu_addr),
        .wdata (cpu_data),
        .raddr (tbl_raddr),
        .rdata (attr)
    );

    assign zone_tick = !beam.hblank && (beam.h[1:0] == 2'd1);

    // zone test against the next line
    always_comb begin
        target = beam.v + 8'd1;         // wraps 255 -> 0
        diff   = target - attr.y;       // mod 256, catches objects wrapping past 255
        hit    = attr.enable && (diff < 8'(obj_pkg::OBJ_H));

        ent_nxt.valid   = 1'b1;
        ent_nxt.obj_id  = beam.h[7:2];  // same slot that addressed the table
        ent_nxt.tile    = attr.tile;
        ent_nxt.palette = attr.palette;
        ent_nxt.hflip   = attr.hflip;
        // row counted from the top, or from the bottom when flipped
        ent_nxt.row     = attr.vflip ? ~diff[3:0] : diff[3:0];
        ent_nxt.sub_x   = attr.x[1:0];
    end

    // write request flag, set for the tick at h mod 4 = 2 only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            we_q <= 1'b0;
        end else if (pxl_cen) begin
            we_q <= zone_tick && hit;
        end
    end

    // request payload, no reset
    always_ff @(posedge clk) begin
        if (pxl_cen && zone_tick) begin
            slot_q  <= attr.x[7:2];     // slot = x / 4
            entry_q <= ent_nxt;
        end
    end

    // one clock wide, lands in the clock of the h mod 4 = 2 tick
    assign wr.we    = we_q && pxl_cen;
    assign wr.slot  = slot_q;
    assign wr.entry = entry_q;

endmodule

// ==== hw/obj_line_buf.sv ====
`timescale 1ns/100ps

module obj_line_buf (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  obj_pkg::beam_t        beam,
    input  obj_pkg::lb_wr_t       wr,
    output logic                  ent_strobe,
    output logic [5:0]            ent_slot,
    output logic [7:0]            ent_line,
    output obj_pkg::line_entry_t  ent
);

    logic                       wr_bank;     // bank of the line being prepared
    logic                       rd_bank;     // bank of the line on screen
    logic                       slot_end;    // h mod 4 = 3 during active time
    logic                       clr_we;
    logic [obj_pkg::SLOT_W-1:0] rd_slot;

    logic                       bank_we    [2];
    logic [obj_pkg::SLOT_W-1:0] bank_waddr [2];
    obj_pkg::line_entry_t       bank_wdata [2];
    obj_pkg::line_entry_t       bank_rdata [2];

    logic                       strobe_q;
    logic [5:0]                 slot_q;
    logic [7:0]                 line_q;

    // ping-pong by line parity, so the two can never match
    assign rd_bank = beam.v[0];
    assign wr_bank = ~beam.v[0];    // parity of v+1

    assign slot_end = !beam.hblank && (beam.h[1:0] == 2'd3);
    assign clr_we   = slot_end && pxl_cen;   // clear in the read tick, one clock
    assign rd_slot  = beam.h[7:2];

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic is_wr;

        assign is_wr = (wr_bank == 1'(b));

        // write bank takes the scanner, read bank clears behind the read
        assign bank_we[b]    = is_wr ? wr.we : clr_we;
        assign bank_waddr[b] = is_wr ? wr.slot : rd_slot;
        assign bank_wdata[b] = is_wr ? wr.entry : obj_pkg::line_entry_t'('0);

        obj_ram #(
            .payload_t (obj_pkg::line_entry_t)
        ) u_bank (
            .clk   (clk),
            .cen   (pxl_cen),
            .we    (bank_we[b]),
            .waddr (bank_waddr[b]),
            .wdata (bank_wdata[b]),
            .raddr (rd_slot),       // only meaningful on the read bank
            .rdata (bank_rdata[b])
        );
    end

    // strobe flag, set by the read tick and dropped on the next one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strobe_q <= 1'b0;
        end else if (pxl_cen) begin
            strobe_q <= slot_end;
        end
    end

    // tags for the slot just read
    always_ff @(posedge clk) begin
        if (pxl_cen && slot_end) begin
            slot_q <= rd_slot;
            line_q <= beam.v;
        end
    end

    // read-first RAM keeps the pre-clear word until the next cen
    assign ent_strobe = strobe_q && pxl_cen;
    assign ent_slot   = slot_q;
    assign ent_line   = line_q;
    assign ent        = bank_rdata[line_q[0]];   // bank that was read for that line

endmodule

// ==== hw/obj_lbuf_top.sv ====
`timescale 1ns/100ps

module obj_lbuf_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  cpu_we,
    input  logic [5:0]            cpu_addr,
    input  obj_pkg::obj_attr_t    cpu_data,
    output obj_pkg::beam_t        beam,
    output logic                  ent_strobe,
    output logic [5:0]            ent_slot,
    output logic [7:0]            ent_line,
    output obj_pkg::line_entry_t  ent
);

    obj_pkg::beam_t  beam_w;    // shared beam position
    obj_pkg::lb_wr_t lb_wr;     // scanner -> line buffer

    // h/v timing
    hv_counter u_hv (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .beam    (beam_w)
    );

    // object table and next-line search
    obj_scan u_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .beam     (beam_w),
        .wr       (lb_wr)
    );

    // ping-pong banks, read and clear
    obj_line_buf u_lbuf (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .beam       (beam_w),
        .wr         (lb_wr),
        .ent_strobe (ent_strobe),
        .ent_slot   (ent_slot),
        .ent_line   (ent_line),
        .ent        (ent)
    );

    assign beam = beam_w;

endmodule

// ==== test/obj_lbuf_chk.sv ====
`timescale 1ns/100ps

module obj_lbuf_chk (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             pxl_cen,
    input  obj_pkg::beam_t   beam,
    input  obj_pkg::lb_wr_t  wr,
    input  logic             wr_bank,
    input  logic             rd_bank,
    input  logic             ent_strobe
);

    int fail_count = 0;    // assertion failure tally

    // strobes only ride on a pixel tick
    a_strobe_cen: assert property (@(posedge clk) disable iff (!rst_n)
        ent_strobe |-> pxl_cen)
        else begin
            $error("ent_strobe high without pxl_cen");
            fail_count = fail_count + 1;
        end

    // blanking is quiet, apart from the strobe of slot 63 at h = 256
    a_strobe_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (ent_strobe && beam.hblank) |-> (beam.h == 9'(obj_pkg::H_ACTIVE)))
        else begin
            $error("ent_strobe during hblank at h = %0d", beam.h);
            fail_count = fail_count + 1;
        end

    // scanner never lands in the bank being read
    a_bank_split: assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |-> (wr_bank != rd_bank))
        else begin
            $error("scanner write hits the read bank");
            fail_count = fail_count + 1;
        end

    a_strobe_rst: assert property (@(posedge clk) !rst_n |=> !ent_strobe)
        else begin
            $error("ent_strobe high in the clock after reset");
            fail_count = fail_count + 1;
        end

endmodule

bind obj_line_buf obj_lbuf_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .pxl_cen    (pxl_cen),
    .beam       (beam),
    .wr         (wr),
    .wr_bank    (wr_bank),
    .rd_bank    (rd_bank),
    .ent_strobe (ent_strobe)
);

// ==== test/obj_lbuf_tb.sv ====
`timescale 1ns/100ps

module obj_lbuf_tb;

    localparam int     N_FRAMES  = 3;      // frames the whole sequence spans, rounded up
    localparam longint TICK_NS   = 8;      // pxl_cen every other 4 ns clock
    localparam longint MARGIN_NS = 20 * obj_pkg::H_TOTAL * TICK_NS;
    localparam longint WDOG_NS   =
        longint'(N_FRAMES) * obj_pkg::H_TOTAL * obj_pkg::V_TOTAL * TICK_NS + MARGIN_NS;

    logic                 clk;
    logic                 rst_n;
    logic                 pxl_cen;
    logic                 cpu_we;
    logic [5:0]           cpu_addr;
    obj_pkg::obj_attr_t   cpu_data;
    obj_pkg::beam_t       beam;
    logic                 ent_strobe;
    logic [5:0]           ent_slot;
    logic [7:0]           ent_line;
    obj_pkg::line_entry_t ent;

    obj_pkg::obj_attr_t   tbl_model [obj_pkg::OBJ_COUNT];   // mirror of every table write
    obj_pkg::line_entry_t got_line  [obj_pkg::OBJ_COUNT];   // last collected line
    logic [31:0]          lcg_state = 32'h8aa7_0f7c;
    int                   n_tests, n_checks, n_errors, n_asserts;

    obj_lbuf_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .pxl_cen    (pxl_cen),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_data   (cpu_data),
        .beam       (beam),
        .ent_strobe (ent_strobe),
        .ent_slot   (ent_slot),
        .ent_line   (ent_line),
        .ent        (ent)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) pxl_cen <= ~pxl_cen;   // one tick every other clock

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // zone and collision rules against the model table
    function automatic obj_pkg::line_entry_t expected_entry(input logic [7:0] line,
                                                            input int slot);
        obj_pkg::line_entry_t e;
        logic [7:0]           diff;
        e = '0;                             // cleared slot reads all zero
        for (int i = 0; i < obj_pkg::OBJ_COUNT; i++) begin
            diff = line - tbl_model[i].y;   // 8-bit, wraps past 255
            if (tbl_model[i].enable && diff < obj_pkg::OBJ_H && tbl_model[i].x / 4 == slot) begin
                e.valid   = 1'b1;           // later index overwrites
                e.obj_id  = 6'(i);
                e.tile    = tbl_model[i].tile;
                e.palette = tbl_model[i].palette;
                e.hflip   = tbl_model[i].hflip;
                e.row     = tbl_model[i].vflip ? 4'(15 - diff) : diff[3:0];
                e.sub_x   = 2'(tbl_model[i].x % 4);
            end
        end
        return e;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("ERR at %0d ns: %s, got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) begin
            $display("test %0d %s: ok", n_tests, name);
        end else begin
            $display("test %0d %s: %0d errors", n_tests, name, n_errors - errs_before);
        end
    endtask

    task automatic write_obj(input int idx, input obj_pkg::obj_attr_t a);
        @(posedge clk);
        cpu_we   <= 1'b1;
        cpu_addr <= 6'(idx);
        cpu_data <= a;
        tbl_model[idx] = a;
        @(posedge clk);
        cpu_we   <= 1'b0;
    endtask

    task automatic write_table();
        for (int i = 0; i < obj_pkg::OBJ_COUNT; i++) begin
            write_obj(i, tbl_model[i]);
        end
    endtask

    // grab all 64 strobes of one line and compare each with the model
    task automatic collect_line(input logic [7:0] line);
        obj_pkg::line_entry_t want;
        do begin
            @(negedge clk);
        end while (!(ent_strobe && ent_line == line && ent_slot == 6'd0));
        for (int s = 0; s < obj_pkg::OBJ_COUNT; s++) begin
            if (s > 0) begin
                do begin
                    @(negedge clk);
                end while (!ent_strobe);
            end
            got_line[s] = ent;
            want = expected_entry(line, s);
            check_val($sformatf("line %0d strobe %0d slot", line, s), ent_slot, s);
            check_val($sformatf("line %0d ent_line vs beam", line), ent_line, beam.v);
            check_val($sformatf("line %0d slot %0d entry", line, s), ent, want);
        end
    endtask

    task automatic test_empty_table();
        int         e0;
        logic [7:0] l0;
        e0 = n_errors;
        for (int i = 0; i < obj_pkg::OBJ_COUNT; i++) begin
            tbl_model[i] = '0;
        end
        write_table();
        l0 = beam.v + 8'd2;                 // skip the two stale lines
        collect_line(l0);
        collect_line(l0 + 8'd1);
        report_test("empty table", e0);
    endtask

    task automatic test_vertical_extent();
        int   e0;
        int   lines [5];
        logic in_zone;
        e0 = n_errors;
        lines = '{39, 40, 47, 55, 56};
        write_obj(3, '{enable: 1'b1, y: 8'd40, x: 8'd77, tile: 7'h11, palette: 3'd2,
                       hflip: 1'b0, vflip: 1'b0});   // slot 19, sub_x 1
        for (int k = 0; k < 5; k++) begin
            collect_line(8'(lines[k]));
            in_zone = (lines[k] >= 40) && (lines[k] <= 55);
            check_val($sformatf("line %0d object shown", lines[k]), got_line[19].valid, in_zone);
            if (in_zone) begin
                check_val("row from top", got_line[19].row, lines[k] - 40);
                check_val("sub_x", got_line[19].sub_x, 1);
            end
        end
        report_test("vertical extent", e0);
    endtask

    task automatic test_attr_fields();
        int e0;
        int lines [3];
        e0 = n_errors;
        lines = '{100, 107, 115};
        write_obj(5, '{enable: 1'b1, y: 8'd100, x: 8'd200, tile: 7'h5a, palette: 3'd5,
                       hflip: 1'b1, vflip: 1'b1});   // slot 50
        for (int k = 0; k < 3; k++) begin
            collect_line(8'(lines[k]));
            check_val("flipped row", got_line[50].row, 15 - (lines[k] - 100));
            check_val("tile", got_line[50].tile, 7'h5a);
            check_val("palette", got_line[50].palette, 3'd5);
            check_val("hflip", got_line[50].hflip, 1'b1);
            check_val("obj_id", got_line[50].obj_id, 5);
        end
        report_test("attribute fields", e0);
    endtask

    task automatic test_collision();
        int         e0;
        logic [7:0] l0;
        e0 = n_errors;
        // both in slot 30, index 20 walked last
        write_obj(10, '{enable: 1'b1, y: 8'd130, x: 8'd120, tile: 7'h0a, palette: 3'd1,
                        hflip: 1'b0, vflip: 1'b0});
        write_obj(20, '{enable: 1'b1, y: 8'd130, x: 8'd123, tile: 7'h14, palette: 3'd6,
                        hflip: 1'b0, vflip: 1'b0});
        collect_line(8'd135);
        check_val("collision winner", got_line[30].obj_id, 20);
        check_val("winner sub_x", got_line[30].sub_x, 3);
        write_obj(10, '0);
        write_obj(20, '0);
        l0 = beam.v + 8'd2;                 // still inside lines 130..145
        collect_line(l0);
        check_val("slot 30 cleared", got_line[30].valid, 0);
        report_test("slot collision", e0);
    endtask

    task automatic test_random_table();
        int          e0;
        logic [31:0] r;
        e0 = n_errors;
        for (int i = 0; i < obj_pkg::OBJ_COUNT; i++) begin
            r = lcg_next();
            tbl_model[i] = obj_pkg::obj_attr_t'(r[28:0]);
            tbl_model[i].enable = r[31] | r[30];     // about three in four
            if (i % 4 == 0) begin
                tbl_model[i].y = 8'd244 + {4'd0, r[29:26]};   // 244..255, 0..3
            end
        end
        write_table();
        collect_line(8'd254);
        collect_line(8'd255);
        collect_line(8'd0);
        collect_line(8'd3);
        report_test("random table with wrap", e0);
    endtask

    // every tick compared with its predecessor until v has wrapped and one more line ended
    task automatic test_beam_counters();
        int             e0;
        int             ends_after;
        obj_pkg::beam_t prev;
        obj_pkg::beam_t cur;
        logic [8:0]     h_want;
        logic [7:0]     v_want;
        logic           h_end;
        logic           seen_vwrap;
        e0 = n_errors;
        ends_after = 0;
        seen_vwrap = 1'b0;
        do begin
            @(negedge clk);
        end while (!pxl_cen);
        prev = beam;
        while (!(seen_vwrap && ends_after >= 1)) begin
            do begin
                @(negedge clk);
            end while (!pxl_cen);
            cur    = beam;
            h_end  = (prev.h == 9'(obj_pkg::H_TOTAL - 1));
            h_want = h_end ? 9'd0 : prev.h + 9'd1;
            v_want = h_end ? prev.v + 8'd1 : prev.v;   // 255 -> 0 by width
            check_val("beam h", cur.h, h_want);
            check_val("beam v", cur.v, v_want);
            check_val("hblank", cur.hblank, cur.h >= obj_pkg::H_ACTIVE);
            if (h_end) begin
                if (seen_vwrap) begin
                    ends_after++;
                end
                if (prev.v == 8'd255 && cur.v == 8'd0) begin
                    seen_vwrap = 1'b1;
                end
            end
            prev = cur;
        end
        report_test("beam counters", e0);
    endtask

    initial begin
        #(WDOG_NS);
        $display("timeout: tests still running after %0d ns, a wait never completed", WDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        pxl_cen  = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        n_tests  = 0;
        n_checks = 0;
        n_errors = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        test_empty_table();
        test_vertical_extent();
        test_attr_fields();
        test_collision();
        test_random_table();
        test_beam_counters();

        n_asserts = DUT.u_lbuf.u_chk.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, n_checks, n_errors, n_asserts);
        if (n_errors == 0 && n_asserts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== obj_lbuf.f ====
hw/obj_pkg.sv
hw/obj_ram.sv
hw/hv_counter.sv
hw/obj_scan.sv
hw/obj_line_buf.sv
hw/obj_lbuf_top.sv
test/obj_lbuf_chk.sv
test/obj_lbuf_tb.sv
